// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	// --------------------
	// issue geometry
	localparam int ISSUE_NUM         = 2;   // only 2 is supported
	localparam int DCACHE_PIPE_DEPTH = 2;
	localparam int QUEUE_DEPTH       = 8;   // has to stay a power of two
	localparam int QUEUE_PTR_W       = $clog2(QUEUE_DEPTH);

	// --------------------
	// vector types
	typedef logic [31:0] uint32_t;
	typedef logic [4:0] reg_addr_t;                      // register 0 stands for no register
	typedef logic [$clog2(ISSUE_NUM+1)-1:0] issue_cnt_t;
	typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;
	typedef logic [QUEUE_PTR_W:0] queue_cnt_t;          // one bit wider so a full queue fits

	typedef enum logic [3:0] {
		OP_NOP,
		OP_ALU,
		OP_LOAD,
		OP_STORE,
		OP_SC,
		OP_BRANCH,
		OP_JUMP,
		OP_MULT,
		OP_MFHILO,
		OP_MTHILO,
		OP_DIV,
		OP_DIVU,
		OP_MFC0,
		OP_MTC0,
		OP_ERET,
		OP_INVALID
	} op_t;

	typedef struct packed {
		logic    valid;
		uint32_t instr;
	} fetch_entry_t;

	typedef struct packed {
		op_t       op;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic      is_load;         // SC counts as a load
		logic      is_store;
		logic      is_controlflow;
		logic      is_priv;
		logic      is_nonrw_priv;   // changes machine state beyond a register, e.g. ERET
		uint32_t   instr;
	} decoded_instr_t;

endpackage

// ==== src/fetch_if.sv ====
`timescale 1ns/100ps

interface fetch_if;
	import cpu_pkg::*;

	fetch_entry_t [ISSUE_NUM-1:0] head;   // oldest entry in slot 0
	issue_cnt_t                   pop;    // entries consumed at the next edge

	modport queue (
		output head,
		input  pop
	);

	modport decode (
		input head
	);

	modport issue (
		input  head,
		output pop
	);

endinterface

// ==== src/issue_if.sv ====
`timescale 1ns/100ps

interface issue_if (input logic clk);
	import cpu_pkg::*;

	decoded_instr_t [ISSUE_NUM-1:0]                        issue_instr;
	issue_cnt_t                                            issue_num;
	decoded_instr_t [ISSUE_NUM-1:0]                        ex_decoded;
	decoded_instr_t [DCACHE_PIPE_DEPTH-1:0][ISSUE_NUM-1:0] dcache_decoded;

	modport issue (
		input  clk,
		output issue_instr,
		output issue_num,
		input  ex_decoded,
		input  dcache_decoded
	);

	modport track (
		input  issue_instr,
		input  issue_num,
		output ex_decoded,
		output dcache_decoded
	);

endinterface

// ==== src/fetch_queue.sv ====
`timescale 1ns/100ps

module fetch_queue (
	input  logic                                       clk,
	input  logic                                       arst_n,
	input  logic [cpu_pkg::ISSUE_NUM-1:0]              in_valid,
	input  cpu_pkg::uint32_t [cpu_pkg::ISSUE_NUM-1:0]  in_instr,
	output logic                                       in_ready,
	fetch_if.queue                                     fq
);
	import cpu_pkg::*;

	fetch_entry_t entries [QUEUE_DEPTH];
	queue_ptr_t   rd_ptr;
	queue_ptr_t   wr_ptr;
	queue_cnt_t   count;
	issue_cnt_t   push_cnt;
	logic         push;

	// room for a whole pair is required before anything is taken
	assign in_ready = count <= queue_cnt_t'(QUEUE_DEPTH - ISSUE_NUM);
	assign push     = in_ready & in_valid[0];
	assign push_cnt = push ? issue_cnt_t'(in_valid[0]) + issue_cnt_t'(in_valid[1]) : '0;

	// --------------------
	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			for (int i = 0; i < ISSUE_NUM; ++i) begin
				if (in_valid[i])
					entries[wr_ptr + queue_ptr_t'(i)] <= '{valid: 1'b1, instr: in_instr[i]};
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + queue_ptr_t'(push_cnt);
			rd_ptr <= rd_ptr + queue_ptr_t'(fq.pop);   // pointers wrap by themselves
			count  <= count + queue_cnt_t'(push_cnt) - queue_cnt_t'(fq.pop);
		end
	end

	// --------------------
	// head of the queue
	always_comb begin
		for (int i = 0; i < ISSUE_NUM; ++i) begin
			fq.head[i]       = entries[rd_ptr + queue_ptr_t'(i)];
			fq.head[i].valid = entries[rd_ptr + queue_ptr_t'(i)].valid
				&& count > queue_cnt_t'(i);               // stale slots read as empty
		end
	end

	// a lone instruction always arrives in slot 0
	a_valid_mask: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid[1] |-> in_valid[0])
		else $error("fetch_queue: fetch_valid mask 10 seen");

	// the issue stage may only take what the queue shows as valid
	a_pop_bound: assert property (@(posedge clk) disable iff (!arst_n)
		fq.pop <= issue_cnt_t'(fq.head[0].valid) + issue_cnt_t'(fq.head[1].valid))
		else $error("fetch_queue: pop of %0d exceeds valid head entries", fq.pop);

endmodule

// ==== src/instr_decode.sv ====
`timescale 1ns/100ps

module instr_decode (
	fetch_if.decode                                           fq,
	output cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] decoded
);
	import cpu_pkg::*;

	function automatic decoded_instr_t decode_word(input uint32_t instr);
		decoded_instr_t d;
		logic [5:0]     opcode;
		logic [5:0]     funct;
		reg_addr_t      rs;
		reg_addr_t      rt;
		opcode  = instr[31:26];
		funct   = instr[5:0];
		rs      = instr[25:21];
		rt      = instr[20:16];
		d       = '0;
		d.instr = instr;
		d.op    = OP_INVALID;
		d.rs1   = rs;                                  // most formats read rs and rt
		d.rs2   = rt;
		case (opcode)
			6'h00: begin                               // R-type
				d.rd = instr[15:11];
				case (funct) inside
					[6'h00:6'h07], [6'h20:6'h2b]: d.op = OP_ALU;
					6'h08, 6'h09: d.op = OP_JUMP;      // jr, jalr
					6'h10, 6'h12: d.op = OP_MFHILO;
					6'h11, 6'h13: d.op = OP_MTHILO;
					6'h18, 6'h19: d.op = OP_MULT;
					6'h1a: d.op = OP_DIV;
					6'h1b: d.op = OP_DIVU;
					default: d.op = OP_INVALID;
				endcase
				d.is_controlflow = d.op == OP_JUMP;
			end
			6'h01: begin                               // regimm branches, rt selects the kind
				d.op             = OP_BRANCH;
				d.rs2            = '0;
				d.rd             = rt[4] ? 5'd31 : 5'd0;
				d.is_controlflow = 1'b1;
			end
			6'h02, 6'h03: begin
				d.op             = OP_JUMP;
				d.rs1            = '0;
				d.rs2            = '0;
				d.rd             = opcode[0] ? 5'd31 : 5'd0;   // jal links to r31
				d.is_controlflow = 1'b1;
			end
			6'h04, 6'h05, 6'h06, 6'h07: begin
				d.op             = OP_BRANCH;
				d.is_controlflow = 1'b1;
			end
			6'h10: begin                               // cop0
				d.rs1     = (rs == 5'h04) ? rt : 5'd0;
				d.rs2     = '0;
				d.rd      = (rs == 5'h00) ? rt : 5'd0;
				d.is_priv = 1'b1;
				if (rs == 5'h00)
					d.op = OP_MFC0;
				else if (rs == 5'h04)
					d.op = OP_MTC0;
				else if (rs[4] && funct == 6'h18) begin
					d.op            = OP_ERET;
					d.is_nonrw_priv = 1'b1;
				end
			end
			6'h1c: begin                               // madd, msub and mul
				d.rd = (funct == 6'h02) ? instr[15:11] : 5'd0;
				d.op = (funct == 6'h02) ? OP_ALU : OP_MULT;
			end
			6'h38: begin
				d.op      = OP_SC;
				d.rd      = rt;                        // success flag comes back in rt
				d.is_load = 1'b1;
			end
			default: begin
				if (opcode[5:3] == 3'b001 || opcode[5:3] == 3'b100 || opcode == 6'h30) begin
					d.op      = (opcode[5] == 1'b1) ? OP_LOAD : OP_ALU;
					d.rs2     = '0;
					d.rd      = rt;
					d.is_load = opcode[5];
				end else if (opcode[5:3] == 3'b101) begin
					d.op       = OP_STORE;
					d.is_store = 1'b1;
				end
			end
		endcase
		return d;
	endfunction

	always_comb begin
		for (int i = 0; i < ISSUE_NUM; ++i)
			decoded[i] = fq.head[i].valid ? decode_word(fq.head[i].instr) : '0;
	end

endmodule

// ==== src/instr_issue.sv ====
`timescale 1ns/100ps

module instr_issue (
	fetch_if.issue                                           fq,
	input  cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] id_decoded,
	input  logic                                             delayslot_not_exec,
	issue_if.issue                                           it,
	output logic                                             stall_req
);
	import cpu_pkg::*;

	// mfhi/mthi/mflo/mtlo, mult/div and the special2 accumulate ops
	function automatic logic uses_hilo(input uint32_t instr);
		return (instr[31:26] == 6'h00 && instr[5:4] == 2'b01 && !instr[2])
			|| (instr[31:26] == 6'h1c && instr[5:3] == 3'b000 && !instr[1]);
	endfunction

	function automatic logic reads_reg(input decoded_instr_t d, input reg_addr_t r);
		return r != '0 && (d.rs1 == r || d.rs2 == r);
	endfunction

	logic [ISSUE_NUM-1:0] head_valid;
	logic [ISSUE_NUM-1:0] mem_access;
	logic [ISSUE_NUM-1:0] hilo_access;
	logic [ISSUE_NUM-1:0] ssnop;
	logic [ISSUE_NUM-1:0] load_use;
	logic                 slot1_withheld;
	logic                 delayslot_load;
	logic                 priv_in_flight;
	logic                 nonrw_in_flight;
	issue_cnt_t           head_cnt;

	for (genvar i = 0; i < ISSUE_NUM; ++i) begin : g_slot
		assign head_valid[i]  = fq.head[i].valid;
		assign mem_access[i]  = id_decoded[i].is_load | id_decoded[i].is_store;
		assign hilo_access[i] = head_valid[i] & uses_hilo(fq.head[i].instr);
		assign ssnop[i]       = head_valid[i] && fq.head[i].instr == 32'h0000_0040;
	end

	assign head_cnt = issue_cnt_t'(head_valid[0]) + issue_cnt_t'(head_valid[1]);

	// --------------------
	// hazards against instructions in flight
	always_comb begin
		load_use        = '0;
		priv_in_flight  = 1'b0;
		nonrw_in_flight = 1'b0;
		delayslot_load  = id_decoded[0].is_load;
		for (int j = 0; j < ISSUE_NUM; ++j) begin
			priv_in_flight  |= it.ex_decoded[j].is_priv;
			nonrw_in_flight |= it.ex_decoded[j].is_nonrw_priv;
			delayslot_load  |= it.ex_decoded[j].is_load;
			for (int k = 0; k < DCACHE_PIPE_DEPTH; ++k) begin
				priv_in_flight  |= it.dcache_decoded[k][j].is_priv;
				nonrw_in_flight |= it.dcache_decoded[k][j].is_nonrw_priv;
			end
			// the last dcache stage forwards its data, earlier ones cannot
			for (int k = 0; k < DCACHE_PIPE_DEPTH - 1; ++k)
				delayslot_load |= it.dcache_decoded[k][j].is_load;
			for (int i = 0; i < ISSUE_NUM; ++i) begin
				if (it.ex_decoded[j].is_load)
					load_use[i] |= reads_reg(id_decoded[i], it.ex_decoded[j].rd);
				for (int k = 0; k < DCACHE_PIPE_DEPTH - 1; ++k) begin
					if (it.dcache_decoded[k][j].is_load)
						load_use[i] |= reads_reg(id_decoded[i], it.dcache_decoded[k][j].rd);
				end
			end
		end
		load_use       &= head_valid;
		delayslot_load &= id_decoded[1].is_controlflow;
	end

	// --------------------
	// pairing
	assign slot1_withheld = !head_valid[1]
		|| reads_reg(id_decoded[1], id_decoded[0].rd)
		|| (mem_access[0] && mem_access[1])
		|| (hilo_access[0] && hilo_access[1])
		|| delayslot_not_exec                       // branch unit says the slot is squashed
		|| delayslot_load
		|| ssnop != '0                              // ssnop takes a cycle to itself
		|| id_decoded[0].op == OP_SC || id_decoded[1].op == OP_SC
		|| id_decoded[0].is_priv || id_decoded[1].is_priv
		|| id_decoded[1].op == OP_DIV || id_decoded[1].op == OP_DIVU;

	assign stall_req = load_use[0]
		|| (load_use[1] && !slot1_withheld)
		|| (id_decoded[0].is_nonrw_priv && priv_in_flight)
		|| nonrw_in_flight
		|| head_valid == '0;

	always_comb begin
		it.issue_instr = id_decoded;
		it.issue_num   = issue_cnt_t'(ISSUE_NUM);
		fq.pop         = it.issue_num;
		if (stall_req) begin
			it.issue_instr = '0;
			it.issue_num   = '0;
			fq.pop         = '0;
		end else if (slot1_withheld) begin
			it.issue_instr[1] = '0;
			it.issue_num      = issue_cnt_t'(1);
			fq.pop            = issue_cnt_t'(1);
		end
	end

	a_issue_bound: assert property (@(posedge it.clk)
		it.issue_num <= issue_cnt_t'(ISSUE_NUM) && it.issue_num <= head_cnt)
		else $error("instr_issue: issue_num %0d with %0d valid entries", it.issue_num, head_cnt);

	a_stall_quiet: assert property (@(posedge it.clk)
		stall_req |-> it.issue_num == '0 && fq.pop == '0)
		else $error("instr_issue: issue during stall");

endmodule

// ==== src/pipe_track.sv ====
`timescale 1ns/100ps

module pipe_track (
	input logic    clk,
	input logic    arst_n,
	issue_if.track it
);
	import cpu_pkg::*;

	decoded_instr_t [ISSUE_NUM-1:0]                        ex_q;
	decoded_instr_t [DCACHE_PIPE_DEPTH-1:0][ISSUE_NUM-1:0] dcache_q;
	logic                                                  issued;

	assign issued = it.issue_num != '0;

	// --------------------
	// shadow of execute and the dcache pipeline
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_q     <= '0;
			dcache_q <= '0;
		end else begin
			ex_q        <= issued ? it.issue_instr : '0;   // a stall enters as a bubble
			dcache_q[0] <= ex_q;
			for (int k = 1; k < DCACHE_PIPE_DEPTH; ++k)
				dcache_q[k] <= dcache_q[k-1];
		end
	end

	assign it.ex_decoded     = ex_q;
	assign it.dcache_decoded = dcache_q;

endmodule

// ==== src/issue_top.sv ====
`timescale 1ns/100ps

module issue_top (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic [cpu_pkg::ISSUE_NUM-1:0] fetch_valid,
	input  cpu_pkg::uint32_t              fetch_instr0,
	input  cpu_pkg::uint32_t              fetch_instr1,
	output logic                          fetch_ready,
	input  logic                          delayslot_not_exec,
	output logic [cpu_pkg::ISSUE_NUM-1:0] issue_valid,
	output cpu_pkg::uint32_t              issue_instr0,
	output cpu_pkg::uint32_t              issue_instr1,
	output logic                          stall_req
);
	import cpu_pkg::*;

	decoded_instr_t [ISSUE_NUM-1:0] id_decoded;

	fetch_if fq_bus ();
	issue_if iss_bus (.clk(clk));

	fetch_queue u_fetch_queue (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (fetch_valid),
		.in_instr ({fetch_instr1, fetch_instr0}),
		.in_ready (fetch_ready),
		.fq       (fq_bus.queue)
	);

	instr_decode u_instr_decode (
		.fq      (fq_bus.decode),
		.decoded (id_decoded)
	);

	instr_issue u_instr_issue (
		.fq                 (fq_bus.issue),
		.id_decoded         (id_decoded),
		.delayslot_not_exec (delayslot_not_exec),
		.it                 (iss_bus.issue),
		.stall_req          (stall_req)
	);

	pipe_track u_pipe_track (
		.clk    (clk),
		.arst_n (arst_n),
		.it     (iss_bus.track)
	);

	// issued slots fill from slot 0 upward
	assign issue_valid[0] = iss_bus.issue_num != '0;
	assign issue_valid[1] = iss_bus.issue_num == issue_cnt_t'(ISSUE_NUM);
	assign issue_instr0   = iss_bus.issue_instr[0].instr;
	assign issue_instr1   = iss_bus.issue_instr[1].instr;

endmodule

// ==== tests/tb_issue_top.sv ====
`timescale 1ns/100ps

module tb_issue_top;
	import cpu_pkg::*;

	localparam int NUM_PAIRS      = 3000;
	localparam int STIM_LEN       = NUM_PAIRS * ISSUE_NUM;
	localparam int TIMEOUT_CYCLES = 2 * STIM_LEN + 100;
	localparam int TRACK_STAGES   = 1 + DCACHE_PIPE_DEPTH;   // execute, then the dcache stages

	typedef struct packed {
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic      load;                                     // SC sets this too
		logic      store;
		logic      cf;
		logic      priv;
		logic      nonrw;
		logic      hilo;
		logic      sc;
		logic      div;
		logic      ssnop;
	} attr_t;

	logic                 clk;
	logic                 arst_n;
	logic [ISSUE_NUM-1:0] fetch_valid;
	uint32_t              fetch_instr0;
	uint32_t              fetch_instr1;
	logic                 fetch_ready;
	logic                 delayslot_not_exec;
	logic [ISSUE_NUM-1:0] issue_valid;
	uint32_t              issue_instr0;
	uint32_t              issue_instr1;
	logic                 stall_req;

	int                   seed = 32'h41f5_00ca;
	int                   cycle_cnt = 0;
	int                   generated = 0;
	int                   accepted = 0;
	uint32_t              mq_word [$];
	attr_t                mq_attr [$];
	attr_t                shadow [TRACK_STAGES][ISSUE_NUM];
	logic                 pair_pending;
	logic [ISSUE_NUM-1:0] pair_mask;
	uint32_t              pair_word [ISSUE_NUM];
	attr_t                pair_attr [ISSUE_NUM];

	issue_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	task automatic end_in_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_instr(input string what, input uint32_t got, input uint32_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			end_in_failure();
		end
	endtask

	task automatic check_count(input string what, input issue_cnt_t got, input issue_cnt_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			end_in_failure();
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
			end_in_failure();
		end
	endtask

	function automatic issue_cnt_t count_from_mask(input logic [ISSUE_NUM-1:0] m);
		case (m)
			2'b00:   return issue_cnt_t'(0);
			2'b01:   return issue_cnt_t'(1);
			2'b11:   return issue_cnt_t'(2);
			default: return issue_cnt_t'(3);                 // never expected, so a 10 mask fails
		endcase
	endfunction

	function automatic logic reads_dest(input attr_t a, input reg_addr_t r);
		return r != 5'd0 && (a.rs1 == r || a.rs2 == r);
	endfunction

	// --------------------
	// stimulus
	task automatic make_instr(output uint32_t w, output attr_t a);
		logic [31:0] r;
		reg_addr_t   rs;
		reg_addr_t   rt;
		reg_addr_t   rd;
		r  = $random(seed);
		rs = {2'b00, r[7:5]};
		rt = {2'b00, r[10:8]};
		rd = {2'b00, r[13:11]};
		a  = '0;
		case (r[4:0])
			5'd12, 5'd13, 5'd14, 5'd15: begin                // lw
				w = {6'h23, rs, rt, r[29:14]};
				a.rs1  = rs;
				a.rd   = rt;
				a.load = 1'b1;
			end
			5'd16, 5'd17: begin                              // sw
				w = {6'h2b, rs, rt, r[29:14]};
				a.rs1   = rs;
				a.rs2   = rt;
				a.store = 1'b1;
			end
			5'd18: begin
				w = {6'h38, rs, rt, r[29:14]};
				a.rs1  = rs;
				a.rs2  = rt;
				a.rd   = rt;
				a.load = 1'b1;
				a.sc   = 1'b1;
			end
			5'd19, 5'd20: begin                              // beq
				w = {6'h04, rs, rt, r[29:14]};
				a.rs1 = rs;
				a.rs2 = rt;
				a.cf  = 1'b1;
			end
			5'd21: begin
				w = {6'h00, rs, rt, 10'd0, 6'h18};
				a.rs1  = rs;
				a.rs2  = rt;
				a.hilo = 1'b1;
			end
			5'd22: begin                                     // mfhi
				w = {6'h00, 10'd0, rd, 5'd0, 6'h10};
				a.rd   = rd;
				a.hilo = 1'b1;
			end
			5'd23: begin
				w = {6'h00, rs, rt, 10'd0, 6'h1a};
				a.rs1  = rs;
				a.rs2  = rt;
				a.hilo = 1'b1;
				a.div  = 1'b1;
			end
			5'd24, 5'd25: begin                              // mfc0 writes rt
				w = {6'h10, 5'h00, rt, r[18:14], 11'd0};
				a.rd   = rt;
				a.priv = 1'b1;
			end
			5'd26: begin
				w = 32'h4200_0018;                           // eret
				a.priv  = 1'b1;
				a.nonrw = 1'b1;
			end
			5'd27: begin
				w = 32'h0000_0040;
				a.ssnop = 1'b1;
			end
			default: begin                                   // addu
				w = {6'h00, rs, rt, rd, 5'd0, 6'h21};
				a.rs1 = rs;
				a.rs2 = rt;
				a.rd  = rd;
			end
		endcase
	endtask

	// --------------------
	// reference model
	task automatic predict_issue(output issue_cnt_t cnt, output logic stall);
		attr_t s [ISSUE_NUM];
		logic  h0;
		logic  h1;
		logic  lu0;
		logic  lu1;
		logic  late_load;
		logic  priv_fl;
		logic  nonrw_fl;
		logic  withhold;
		h0        = mq_word.size() > 0;
		h1        = mq_word.size() > 1;
		s[0]      = h0 ? mq_attr[0] : '0;
		s[1]      = h1 ? mq_attr[1] : '0;
		lu0       = 1'b0;
		lu1       = 1'b0;
		late_load = 1'b0;
		priv_fl   = 1'b0;
		nonrw_fl  = 1'b0;
		for (int st = 0; st < TRACK_STAGES; st++) begin
			for (int j = 0; j < ISSUE_NUM; j++) begin
				priv_fl  |= shadow[st][j].priv;
				nonrw_fl |= shadow[st][j].nonrw;
				if (st < TRACK_STAGES - 1 && shadow[st][j].load) begin   // last stage forwards
					late_load = 1'b1;
					lu0 |= reads_dest(s[0], shadow[st][j].rd);
					lu1 |= reads_dest(s[1], shadow[st][j].rd);
				end
			end
		end
		withhold = !h1 || reads_dest(s[1], s[0].rd)
			|| ((s[0].load || s[0].store) && (s[1].load || s[1].store))
			|| (s[0].hilo && s[1].hilo) || delayslot_not_exec
			|| (s[1].cf && (s[0].load || late_load))
			|| s[0].ssnop || s[1].ssnop || s[0].sc || s[1].sc
			|| s[0].priv || s[1].priv || s[1].div;
		stall = !h0 || lu0 || (lu1 && !withhold) || (s[0].nonrw && priv_fl) || nonrw_fl;
		cnt   = stall ? issue_cnt_t'(0) : (withhold ? issue_cnt_t'(1) : issue_cnt_t'(2));
	endtask

	task automatic advance_model(input issue_cnt_t cnt);
		for (int st = TRACK_STAGES - 1; st > 0; st--) begin
			for (int j = 0; j < ISSUE_NUM; j++)
				shadow[st][j] = shadow[st-1][j];
		end
		for (int j = 0; j < ISSUE_NUM; j++)
			shadow[0][j] = (j < int'(cnt)) ? mq_attr[j] : '0;
		for (int j = 0; j < int'(cnt); j++) begin
			void'(mq_word.pop_front());
			void'(mq_attr.pop_front());
		end
	endtask

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout after %0d cycles with %0d of %0d pairs accepted and %0d words queued",
			cycle_cnt, accepted, NUM_PAIRS, mq_word.size());
		end_in_failure();
	end

	initial begin
		logic [31:0] r;
		issue_cnt_t  exp_cnt;
		logic        exp_stall;
		logic        exp_ready;
		arst_n             = 1'b0;
		fetch_valid        = '0;
		fetch_instr0       = '0;
		fetch_instr1       = '0;
		delayslot_not_exec = 1'b0;
		pair_pending       = 1'b0;
		pair_mask          = '0;
		for (int st = 0; st < TRACK_STAGES; st++) begin
			for (int j = 0; j < ISSUE_NUM; j++)
				shadow[st][j] = '0;
		end
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		#1;
		check_bit("fetch_ready after reset", fetch_ready, 1'b1);
		check_bit("stall_req after reset", stall_req, 1'b1);
		check_count("issue count after reset", count_from_mask(issue_valid), issue_cnt_t'(0));

		while (accepted < NUM_PAIRS || pair_pending || mq_word.size() != 0) begin
			@(negedge clk);
			r = $random(seed);
			if (!pair_pending && generated < NUM_PAIRS && r[2:0] != 3'd0) begin
				make_instr(pair_word[0], pair_attr[0]);
				make_instr(pair_word[1], pair_attr[1]);
				pair_mask    = (r[9:8] == 2'd0) ? 2'b01 : 2'b11;
				pair_pending = 1'b1;
				generated++;
			end
			fetch_valid        = pair_pending ? pair_mask : 2'b00;
			fetch_instr0       = pair_word[0];
			fetch_instr1       = pair_word[1];
			delayslot_not_exec = r[6:4] == 3'd0;
			predict_issue(exp_cnt, exp_stall);
			exp_ready = mq_word.size() <= QUEUE_DEPTH - ISSUE_NUM;
			#1;                                              // outputs settle well before the edge
			check_bit("fetch_ready", fetch_ready, exp_ready);
			check_bit("stall_req", stall_req, exp_stall);
			check_count("issue count", count_from_mask(issue_valid), exp_cnt);
			if (exp_cnt >= issue_cnt_t'(1))
				check_instr("issue_instr0", issue_instr0, mq_word[0]);
			if (exp_cnt == issue_cnt_t'(2))
				check_instr("issue_instr1", issue_instr1, mq_word[1]);

			// what the coming rising edge does to the queue and the pipeline
			advance_model(exp_cnt);
			if (pair_pending && exp_ready) begin
				for (int j = 0; j < ISSUE_NUM; j++) begin
					if (pair_mask[j]) begin
						mq_word.push_back(pair_word[j]);
						mq_attr.push_back(pair_attr[j]);
					end
				end
				pair_pending = 1'b0;
				accepted++;
			end
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
src/cpu_pkg.sv
src/fetch_if.sv
src/issue_if.sv
src/fetch_queue.sv
src/instr_decode.sv
src/instr_issue.sv
src/pipe_track.sv
src/issue_top.sv
tests/tb_issue_top.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_issue_top
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -j 0
BUILD    = obj_dir
EXE      = $(BUILD)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(EXE)
	./$(EXE)

clean:
	rm -rf $(BUILD)
